// ==== hw/xform_pkg.sv ====
package xform_pkg;

    localparam int IN_W = 24;
    localparam int IN_FRAC = 13;
    localparam int NDC_W = 16;
    localparam int NDC_INT = NDC_W - IN_FRAC;   // Integer bits of a quotient.
    localparam int PIX_W = 12;
    localparam int DEPTH_W = 12;

    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 320;
    localparam int SCREEN_HALF_W = SCREEN_W / 2;
    localparam int SCREEN_HALF_H = SCREEN_H / 2;

    localparam int NDC_ONE = 1 << IN_FRAC;
    localparam int DEPTH_MAX = (1 << DEPTH_W) - 1;

    // Two guard bits above the product width hold the four-term row sum.
    localparam int ACC_W = 2 * IN_W + 2;

    localparam int DIV_CNT_W = $clog2(NDC_W);
    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(NDC_W - 1);

    typedef logic signed [IN_W-1:0] coord_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        coord_t w;
    } vec4_t;

    // Row r0 yields clip x, r3 yields clip w.
    typedef struct packed {
        vec4_t r0;
        vec4_t r1;
        vec4_t r2;
        vec4_t r3;
    } mat4_t;

    typedef struct packed {
        logic signed [NDC_W-1:0] x;
        logic signed [NDC_W-1:0] y;
        logic signed [NDC_W-1:0] z;
    } ndc_t;

    typedef struct packed {
        logic signed [PIX_W-1:0] x;
        logic signed [PIX_W-1:0] y;
        logic [DEPTH_W-1:0]      z;
    } pixel_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

// ==== hw/viewport_map.sv ====
`timescale 1ns/1ps

module viewport_map (
    input  xform_pkg::ndc_t   i_ndc,
    output xform_pkg::pixel_t o_pixel
);

    int sx;
    int sy;
    int sz;
    int px;
    int py;
    int dz;

    always_comb begin
        // Move each coordinate from [-1, 1] into [0, 2], still Q13.
        sx = int'(i_ndc.x) + xform_pkg::NDC_ONE;
        sy = xform_pkg::NDC_ONE - int'(i_ndc.y);    // Top row is NDC y of +1.
        sz = int'(i_ndc.z) + xform_pkg::NDC_ONE;

        px = (sx * xform_pkg::SCREEN_HALF_W) >>> xform_pkg::IN_FRAC;
        py = (sy * xform_pkg::SCREEN_HALF_H) >>> xform_pkg::IN_FRAC;

        // Halve, then keep the top DEPTH_W fraction bits.
        dz = sz >>> (xform_pkg::IN_FRAC - xform_pkg::DEPTH_W + 1);

        o_pixel.x = px[xform_pkg::PIX_W-1:0];
        o_pixel.y = py[xform_pkg::PIX_W-1:0];

        if (dz > xform_pkg::DEPTH_MAX)
            o_pixel.z = '1;     // z of exactly +1 lands one past the top.
        else
            o_pixel.z = dz[xform_pkg::DEPTH_W-1:0];
    end

endmodule

// ==== hw/mvp_transform.sv ====
`timescale 1ns/1ps

module mvp_transform (
    input  logic              clk,
    input  logic              rstn,
    input  xform_pkg::mat4_t  i_mvp,
    input  logic              i_mvp_dv,
    input  xform_pkg::vec3_t  i_vertex,
    input  logic              i_vertex_dv,
    input  logic              i_vertex_last,
    input  logic              i_enable,
    output logic              o_busy,
    output xform_pkg::vec4_t  o_vertex,
    output logic              o_vertex_dv,
    output logic              o_vertex_last
);

    xform_pkg::mat4_t  mvp_q;
    xform_pkg::coord_t m [4][4];
    xform_pkg::coord_t v [3];
    xform_pkg::acc_t   term_q [4][4];
    xform_pkg::acc_t   sum [4];

    logic       accept;
    logic [1:0] dv_sr;
    logic [1:0] last_sr;

    assign accept = i_vertex_dv & i_enable;

    always_comb begin
        m[0] = '{mvp_q.r0.x, mvp_q.r0.y, mvp_q.r0.z, mvp_q.r0.w};
        m[1] = '{mvp_q.r1.x, mvp_q.r1.y, mvp_q.r1.z, mvp_q.r1.w};
        m[2] = '{mvp_q.r2.x, mvp_q.r2.y, mvp_q.r2.z, mvp_q.r2.w};
        m[3] = '{mvp_q.r3.x, mvp_q.r3.y, mvp_q.r3.z, mvp_q.r3.w};
        v = '{i_vertex.x, i_vertex.y, i_vertex.z};
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mvp_q <= '0;
            dv_sr <= '0;
            last_sr <= '0;
        end else begin
            if (i_mvp_dv)
                mvp_q <= i_mvp;     // Takes effect for the next accepted vertex.
            dv_sr <= {dv_sr[0], accept};
            last_sr <= {last_sr[0], accept & i_vertex_last};
        end
    end

    // Stage one. The w input is an implied 1.0, so the fourth column is just
    // brought up to the product scale.
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 3; c++) begin
                    term_q[r][c] <= xform_pkg::acc_t'(m[r][c]) * xform_pkg::acc_t'(v[c]);
                end
                term_q[r][3] <= xform_pkg::acc_t'(m[r][3]) <<< xform_pkg::IN_FRAC;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            sum[r] = term_q[r][0] + term_q[r][1] + term_q[r][2] + term_q[r][3];
        end
    end

    // Stage two. Dropping the low IN_FRAC bits of a two's complement sum
    // rounds toward minus infinity.
    always_ff @(posedge clk) begin
        if (dv_sr[0]) begin
            o_vertex.x <= sum[0][xform_pkg::IN_FRAC +: xform_pkg::IN_W];
            o_vertex.y <= sum[1][xform_pkg::IN_FRAC +: xform_pkg::IN_W];
            o_vertex.z <= sum[2][xform_pkg::IN_FRAC +: xform_pkg::IN_W];
            o_vertex.w <= sum[3][xform_pkg::IN_FRAC +: xform_pkg::IN_W];
        end
    end

    assign o_vertex_dv = dv_sr[1];
    assign o_vertex_last = last_sr[1];
    assign o_busy = |dv_sr;

endmodule

// ==== hw/persp_divide.sv ====
`timescale 1ns/1ps

module persp_divide (
    input  logic              clk,
    input  logic              rstn,
    input  xform_pkg::vec4_t  i_vertex,
    input  logic              i_vertex_dv,
    output logic              o_busy,
    output xform_pkg::ndc_t   o_ndc,
    output logic              o_invalid,
    output logic              o_done
);

    xform_pkg::div_state_e           state;
    logic [xform_pkg::DIV_CNT_W-1:0] count;

    xform_pkg::coord_t            num [3];
    logic [xform_pkg::IN_W-1:0]   num_mag [3];
    logic [2:0]                   num_neg;
    logic [xform_pkg::IN_W-1:0]   w_mag;

    logic [xform_pkg::IN_W-1:0]   w_q;
    logic                         w_bad_q;
    logic [2:0]                   neg_q;
    logic [2:0]                   ovf_q;
    logic [xform_pkg::IN_W-1:0]   rem_q [3];
    logic [xform_pkg::NDC_W-1:0]  quo_q [3];   // Low dividend bits, then quotient.

    logic [xform_pkg::IN_W:0]        trial [3];
    logic [xform_pkg::IN_W:0]        rem_nx [3];
    logic [2:0]                      take;
    logic [2:0]                      big;
    logic signed [xform_pkg::NDC_W-1:0] quo_s [3];

    always_comb begin
        num = '{i_vertex.x, i_vertex.y, i_vertex.z};
        for (int i = 0; i < 3; i++) begin
            num_neg[i] = num[i][xform_pkg::IN_W-1];
            num_mag[i] = num_neg[i] ? -num[i] : num[i];
        end
        w_mag = i_vertex.w[xform_pkg::IN_W-1] ? -i_vertex.w : i_vertex.w;
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            trial[i] = {rem_q[i], quo_q[i][xform_pkg::NDC_W-1]};
            take[i] = trial[i] >= {1'b0, w_q};
            rem_nx[i] = take[i] ? trial[i] - {1'b0, w_q} : trial[i];
            big[i] = quo_q[i] > xform_pkg::NDC_ONE[xform_pkg::NDC_W-1:0];
            quo_s[i] = neg_q[i] ? -quo_q[i] : quo_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= xform_pkg::DIV_IDLE;
            count <= '0;
            o_invalid <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                xform_pkg::DIV_IDLE: begin
                    if (i_vertex_dv) begin
                        state <= xform_pkg::DIV_RUN;
                        count <= '0;
                    end
                end
                xform_pkg::DIV_RUN: begin
                    count <= count + 1'b1;
                    if (count == xform_pkg::DIV_LAST)
                        state <= xform_pkg::DIV_DONE;
                end
                xform_pkg::DIV_DONE: begin
                    o_invalid <= w_bad_q | (|ovf_q) | (|big);
                    o_done <= 1'b1;
                    state <= xform_pkg::DIV_IDLE;
                end
                default: state <= xform_pkg::DIV_IDLE;
            endcase
        end
    end

    // A quotient that needs more than NDC_INT integer bits is caught at load,
    // since sixteen restoring steps cannot produce it.
    always_ff @(posedge clk) begin
        case (state)
            xform_pkg::DIV_IDLE: begin
                if (i_vertex_dv) begin
                    w_q <= w_mag;
                    w_bad_q <= i_vertex.w[xform_pkg::IN_W-1] || (i_vertex.w == '0);
                    for (int i = 0; i < 3; i++) begin
                        neg_q[i] <= num_neg[i];
                        ovf_q[i] <= (num_mag[i] >> xform_pkg::NDC_INT) >= w_mag;
                        rem_q[i] <= num_mag[i] >> xform_pkg::NDC_INT;
                        quo_q[i] <= {num_mag[i][xform_pkg::NDC_INT-1:0],
                                     {xform_pkg::IN_FRAC{1'b0}}};
                    end
                end
            end
            xform_pkg::DIV_RUN: begin
                for (int i = 0; i < 3; i++) begin
                    rem_q[i] <= rem_nx[i][xform_pkg::IN_W-1:0];
                    quo_q[i] <= {quo_q[i][xform_pkg::NDC_W-2:0], take[i]};
                end
            end
            xform_pkg::DIV_DONE: begin
                o_ndc.x <= quo_s[0];
                o_ndc.y <= quo_s[1];
                o_ndc.z <= quo_s[2];
            end
            default: ;
        endcase
    end

    assign o_busy = (state != xform_pkg::DIV_IDLE) || o_done;  // Held through done.

endmodule

// ==== hw/transform_pipeline.sv ====
`timescale 1ns/1ps

module transform_pipeline (
    input  logic              clk,
    input  logic              rstn,
    input  xform_pkg::mat4_t  i_mvp,
    input  logic              i_mvp_dv,
    input  xform_pkg::vec3_t  i_vertex,
    input  logic              i_vertex_dv,
    input  logic              i_vertex_last,
    output logic              o_ready,
    output xform_pkg::vec4_t  o_vs_vertex,
    output logic              o_vs_vertex_dv,
    output xform_pkg::pixel_t o_vertex,
    output logic              o_vertex_dv,
    output logic              o_error,
    output logic              o_finished
);

    logic              mvp_busy;
    xform_pkg::vec4_t  clip_vertex;
    logic              clip_dv;
    logic              clip_last;
    logic              vs_last_q;

    logic              div_busy;
    xform_pkg::ndc_t   ndc;
    logic              div_invalid;
    logic              div_done;
    logic              div_last_q;

    xform_pkg::pixel_t pixel;

    mvp_transform mvp_transform_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_mvp         (i_mvp),
        .i_mvp_dv      (i_mvp_dv),
        .i_vertex      (i_vertex),
        .i_vertex_dv   (i_vertex_dv),
        .i_vertex_last (i_vertex_last),
        .i_enable      (o_ready),
        .o_busy        (mvp_busy),
        .o_vertex      (clip_vertex),
        .o_vertex_dv   (clip_dv),
        .o_vertex_last (clip_last)
    );

    persp_divide persp_divide_inst (
        .clk         (clk),
        .rstn        (rstn),
        .i_vertex    (o_vs_vertex),
        .i_vertex_dv (o_vs_vertex_dv),
        .o_busy      (div_busy),
        .o_ndc       (ndc),
        .o_invalid   (div_invalid),
        .o_done      (div_done)
    );

    viewport_map viewport_map_inst (
        .i_ndc   (ndc),
        .o_pixel (pixel)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_vs_vertex_dv <= 1'b0;
            vs_last_q <= 1'b0;
            div_last_q <= 1'b0;
            o_vertex_dv <= 1'b0;
            o_error <= 1'b0;
            o_finished <= 1'b0;
        end else begin
            o_vs_vertex_dv <= clip_dv;
            vs_last_q <= clip_dv & clip_last;
            if (o_vs_vertex_dv)
                div_last_q <= vs_last_q;    // Rides beside the divider.
            o_vertex_dv <= div_done;
            o_error <= div_done & div_invalid;
            o_finished <= div_done & div_last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (clip_dv)
            o_vs_vertex <= clip_vertex;
        if (div_done && !div_invalid)
            o_vertex <= pixel;  // An invalid vertex leaves the last good one.
    end

    // One vertex at a time from acceptance until the divider has finished.
    assign o_ready = !(mvp_busy || o_vs_vertex_dv || div_busy);

endmodule

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_count = 0;
int tests_passed = 0;
int tests_failed = 0;

task automatic check_clip(input string name, input xform_pkg::vec4_t exp,
                          input xform_pkg::vec4_t act);
    if (act !== exp) begin
        $display("ERR %s clip expected %h %h %h %h actual %h %h %h %h", name,
                 exp.x, exp.y, exp.z, exp.w, act.x, act.y, act.z, act.w);
        err_count++;
    end
endtask

task automatic check_pixel(input string name, input xform_pkg::pixel_t exp,
                           input xform_pkg::pixel_t act);
    if (act !== exp) begin
        $display("ERR %s pixel expected %0d %0d %0d actual %0d %0d %0d", name,
                 exp.x, exp.y, exp.z, act.x, act.y, act.z);
        err_count++;
    end
endtask

task automatic check_flag(input string name, input string what, input bit exp, input bit act);
    if (act != exp) begin
        $display("ERR %s %s expected %0d actual %0d", name, what, exp, act);
        err_count++;
    end
endtask

task automatic check_latency(input string name, input string what, input int exp,
                             input int act);
    if (act != exp) begin
        $display("ERR %s %s expected %0d actual %0d", name, what, exp, act);
        err_count++;
    end
endtask

task automatic note_failure(input string name, input string what);
    $display("%s: %s", name, what);
    err_count++;
endtask

// One line per test, counted as passed when no new error came in.
task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
        tests_passed++;
        $display("PASS %s", name);
    end else begin
        tests_failed++;
        $display("FAIL %s", name);
    end
endtask

`endif

// ==== bench/tb_transform_pipeline.sv ====
`timescale 1ns/1ps

module tb_transform_pipeline;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int VS_LATENCY = 3;
    localparam int OUT_LATENCY = 22;
    localparam int STRAY_CYCLE = 5;    // A strobe sent here must be ignored.

    logic              clk;
    logic              rstn;
    xform_pkg::mat4_t  i_mvp;
    logic              i_mvp_dv;
    xform_pkg::vec3_t  i_vertex;
    logic              i_vertex_dv;
    logic              i_vertex_last;
    logic              o_ready;
    xform_pkg::vec4_t  o_vs_vertex;
    logic              o_vs_vertex_dv;
    xform_pkg::pixel_t o_vertex;
    logic              o_vertex_dv;
    logic              o_error;
    logic              o_finished;

    int fd;
    bit abort_run;

    `include "tb_checks.svh"

    transform_pipeline transform_pipeline_inst (
        .clk            (clk),
        .rstn           (rstn),
        .i_mvp          (i_mvp),
        .i_mvp_dv       (i_mvp_dv),
        .i_vertex       (i_vertex),
        .i_vertex_dv    (i_vertex_dv),
        .i_vertex_last  (i_vertex_last),
        .o_ready        (o_ready),
        .o_vs_vertex    (o_vs_vertex),
        .o_vs_vertex_dv (o_vs_vertex_dv),
        .o_vertex       (o_vertex),
        .o_vertex_dv    (o_vertex_dv),
        .o_error        (o_error),
        .o_finished     (o_finished)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [xform_pkg::IN_W-1:0] read_hex();
        int code;
        logic [xform_pkg::IN_W-1:0] val;
        val = '0;
        code = $fscanf(fd, "%h", val);
        if (code != 1) begin
            $display("The stimulus file ended inside a record or held a bad value.");
            err_count++;
            abort_run = 1'b1;
        end
        return val;
    endfunction

    task automatic load_matrix();
        logic [16*xform_pkg::IN_W-1:0] raw;
        raw = '0;
        for (int i = 0; i < 16; i++) begin
            raw = {raw[15*xform_pkg::IN_W-1:0], read_hex()};    // First value ends in r0.x.
        end
        i_mvp = raw;
        i_mvp_dv = 1'b1;
        @(posedge clk);
        #1;
        i_mvp_dv = 1'b0;
    endtask

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        while (!o_ready && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!o_ready) begin
            note_failure(name, "o_ready never went high within 100 cycles");
            abort_run = 1'b1;
        end
    endtask

    task automatic run_vertex(input string name, input xform_pkg::vec3_t vtx, input bit last,
                              input xform_pkg::vec4_t exp_clip, input xform_pkg::pixel_t exp_pix,
                              input bit exp_inv, input bit exp_fin);
        int cycles;
        int vs_cycle;
        int errs_before;
        bit seen_out;
        bit busy_ready;
        bit early_flag;
        errs_before = err_count;
        cycles = 0;
        vs_cycle = 0;
        seen_out = 1'b0;
        busy_ready = 1'b0;
        early_flag = 1'b0;
        wait_ready(name);
        if (!abort_run) begin
            i_vertex = vtx;
            i_vertex_last = last;
            i_vertex_dv = 1'b1;
            while (!seen_out && cycles < TIMEOUT_CYCLES) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles == 1) begin
                    i_vertex_dv = 1'b0;
                    i_vertex_last = 1'b0;
                end else if (cycles == STRAY_CYCLE) begin
                    i_vertex = ~vtx;
                    i_vertex_last = 1'b1;
                    i_vertex_dv = 1'b1;
                end else if (cycles == STRAY_CYCLE + 1) begin
                    i_vertex_dv = 1'b0;
                    i_vertex_last = 1'b0;
                end
                if (o_vs_vertex_dv) begin
                    if (vs_cycle == 0) begin
                        vs_cycle = cycles;
                        check_clip(name, exp_clip, o_vs_vertex);
                    end else begin
                        note_failure(name, "a strobe sent while o_ready was low was accepted");
                    end
                end
                if (o_vertex_dv) begin
                    seen_out = 1'b1;
                end else begin
                    if (o_ready && !busy_ready) begin
                        busy_ready = 1'b1;
                        note_failure(name, "o_ready was high while the vertex was in flight");
                    end
                    if ((o_error || o_finished) && !early_flag) begin
                        early_flag = 1'b1;
                        note_failure(name, "o_error or o_finished pulsed without o_vertex_dv");
                    end
                end
            end
            if (vs_cycle == 0)
                note_failure(name, "o_vs_vertex_dv never came");
            else
                check_latency(name, "clip latency", VS_LATENCY, vs_cycle);
            if (!seen_out) begin
                note_failure(name, "o_vertex_dv never came within 100 cycles");
                abort_run = 1'b1;
            end else begin
                check_latency(name, "output latency", OUT_LATENCY, cycles);
                check_pixel(name, exp_pix, o_vertex);
                check_flag(name, "o_error", exp_inv, o_error);
                check_flag(name, "o_finished", exp_fin, o_finished);
                check_flag(name, "o_ready", 1'b1, o_ready);
            end
        end
        finish_test(name, errs_before);
    endtask

    task automatic read_vertex();
        int code;
        string name;
        logic [8*16-1:0] name_raw;
        logic [xform_pkg::IN_W-1:0] val;
        xform_pkg::vec3_t vtx;
        xform_pkg::vec4_t clip;
        xform_pkg::pixel_t pix;
        bit last;
        bit inv;
        bit fin;
        code = $fscanf(fd, "%s", name_raw);
        name = $sformatf("%0s", name_raw);
        vtx.x = read_hex();
        vtx.y = read_hex();
        vtx.z = read_hex();
        val = read_hex();
        last = val[0];
        clip.x = read_hex();
        clip.y = read_hex();
        clip.z = read_hex();
        clip.w = read_hex();
        val = read_hex();
        pix.x = val[xform_pkg::PIX_W-1:0];
        val = read_hex();
        pix.y = val[xform_pkg::PIX_W-1:0];
        val = read_hex();
        pix.z = val[xform_pkg::DEPTH_W-1:0];
        val = read_hex();
        inv = val[0];
        val = read_hex();
        fin = val[0];
        if (code != 1 || abort_run)
            note_failure("stimulus", "a vertex record could not be read");
        else
            run_vertex(name, vtx, last, clip, pix, inv, fin);
    endtask

    initial begin
        logic [7:0] kind;
        logic [8*200-1:0] line_buf;
        int code;
        int reset_errs;
        bit done_reading;
        rstn = 1'b0;
        i_mvp = '0;
        i_mvp_dv = 1'b0;
        i_vertex = '0;
        i_vertex_dv = 1'b0;
        i_vertex_last = 1'b0;
        abort_run = 1'b0;
        done_reading = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        reset_errs = err_count;
        check_flag("reset", "o_ready", 1'b1, o_ready);
        check_flag("reset", "o_vertex_dv", 1'b0, o_vertex_dv);
        check_flag("reset", "o_vs_vertex_dv", 1'b0, o_vs_vertex_dv);
        check_flag("reset", "o_error", 1'b0, o_error);
        check_flag("reset", "o_finished", 1'b0, o_finished);
        finish_test("reset", reset_errs);
        fd = $fopen("bench/stim_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/stim_vectors.txt for reading.");
            err_count++;
        end else begin
            while (!done_reading && !abort_run) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1)
                    done_reading = 1'b1;
                else if (kind == "#")
                    code = $fgets(line_buf, fd);    // Rest of a comment line.
                else if (kind == "M")
                    load_matrix();
                else if (kind == "V")
                    read_vertex();
                else begin
                    $display("The stimulus file holds an unknown record type.");
                    err_count++;
                    abort_run = 1'b1;
                end
            end
            $fclose(fd);
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0 && tests_passed > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+bench
hw/xform_pkg.sv
hw/viewport_map.sv
hw/mvp_transform.sv
hw/persp_divide.sv
hw/transform_pipeline.sv
bench/tb_transform_pipeline.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_transform_pipeline
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep '\.sv$$' $(FILELIST))
HEADERS := bench/tb_checks.svh
STIM    := bench/stim_vectors.txt

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM) $(STIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Regression failed" $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/stim_vectors.txt ====
# M: sixteen Q13 hex matrix values r0.x r0.y r0.z r0.w r1.x ... r3.w
# V: name x y z last clip.x clip.y clip.z clip.w pix.x pix.y depth invalid finished
M 002000 000000 000000 000000 000000 002000 000000 000000 000000 000000 002000 000000 000000 000000 000000 002000
V id_origin 000000 000000 000000 0 000000 000000 000000 002000 0a0 0a0 800 0 0
V id_half 001000 fff800 001800 0 001000 fff800 001800 002000 0f0 0c8 e00 0 0
V id_frac 000123 000123 000123 0 000123 000123 000123 002000 0a5 09a 848 0 0
V id_corner 002000 002000 002000 0 002000 002000 002000 002000 140 000 fff 0 0
V id_neg ffe000 ffe000 ffe000 1 ffe000 ffe000 ffe000 002000 000 140 000 0 1
M 003000 000000 000000 000000 000000 002000 000000 000400 000000 000000 001000 000800 000000 000000 fff000 004000
V persp_a 000333 fffaab 001001 0 0004cc fffeab 001000 0037ff 0ad 0a3 a49 0 0
V persp_b ffe800 001000 ffe000 0 ffdc00 001400 fff800 005000 058 078 733 0 0
V inv_w_zero 000000 000000 008000 0 000000 000400 004800 000000 058 078 733 1 0
V inv_w_neg 000000 000000 00c000 0 000000 000400 006800 ffe000 058 078 733 1 0
V inv_range 004000 000000 000000 0 006000 000400 000800 004000 058 078 733 1 0
V inv_ovf 100000 000000 000000 0 180000 000400 000800 004000 058 078 733 1 0
V persp_last ffffff 000003 fffffd 1 fffffe 000403 0007fe 004001 0a0 095 8ff 0 1
M 001000 000000 000000 000000 000000 001000 000000 000000 000000 000000 001000 000000 000000 000000 000000 002000
V half_scale 001000 001000 001000 0 000800 000800 000800 002000 0c8 078 a00 0 0
M 002000 000000 000000 000000 000000 002000 000000 000000 000000 000000 002000 000000 000000 000000 000000 002000
V back_ident 001000 001000 001000 1 001000 001000 001000 002000 0f0 050 c00 0 1
